// File: hw/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// Widths and counts
`define ICACHE_ADDR_W      32
`define ICACHE_DATA_W      32
`define ICACHE_WAYS        4
`define ICACHE_WAY_W       2
`define ICACHE_SET_W       4
`define ICACHE_WORD_W      4
`define ICACHE_SETS        (1 << `ICACHE_SET_W)
`define ICACHE_LINE_WORDS  (1 << `ICACHE_WORD_W)

// Tag is what is left above byte, word and set bits
`define ICACHE_TAG_W       (`ICACHE_ADDR_W - 2 - `ICACHE_SET_W - `ICACHE_WORD_W)

// Field positions in a byte address
`define ICACHE_WORD_LSB    2
`define ICACHE_SET_LSB     (`ICACHE_WORD_LSB + `ICACHE_WORD_W)
`define ICACHE_TAG_LSB     (`ICACHE_SET_LSB + `ICACHE_SET_W)

`endif

// File: hw/icache_pkg.sv
`default_nettype none

`include "icache_macros.svh"

package icache_pkg;

  // Storage and bus words
  typedef logic [`ICACHE_DATA_W-1:0] word_t;
  typedef logic [`ICACHE_ADDR_W-1:0] addr_t;

  // Address fields
  typedef logic [`ICACHE_TAG_W-1:0]  tag_t;
  typedef logic [`ICACHE_SET_W-1:0]  set_t;
  typedef logic [`ICACHE_WORD_W-1:0] word_idx_t;

  // Way bookkeeping
  typedef logic [`ICACHE_WAY_W-1:0]  way_t;
  typedef logic [`ICACHE_WAY_W-1:0]  age_t;
  typedef logic [`ICACHE_WAYS-1:0]   way_mask_t;

endpackage

`default_nettype wire

// File: hw/sdp_ram.sv
`timescale 1ns/1ps
`default_nettype none

module sdp_ram #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 16
) (
  input  wire logic                     clk,
  input  wire logic                     we,
  input  wire logic [$clog2(DEPTH)-1:0] waddr,
  input  wire payload_t                 wdata,
  input  wire logic [$clog2(DEPTH)-1:0] raddr,
  output payload_t                      rdata
);

  payload_t mem [DEPTH];

  // Write port
  always_ff @(posedge clk)
  begin
    if (we)
    begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read, old data on a same-cycle collision
  always_ff @(posedge clk)
  begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

// File: hw/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module cache_way (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire icache_pkg::set_t      rd_set,
  input  wire icache_pkg::word_idx_t rd_word,
  input  wire icache_pkg::tag_t      rd_tag,
  input  wire logic                  tag_we,
  input  wire icache_pkg::set_t      wr_set,
  input  wire icache_pkg::tag_t      wr_tag,
  input  wire logic                  data_we,
  input  wire icache_pkg::word_idx_t wr_word,
  input  wire icache_pkg::word_t     wr_data,
  output logic                       hit,
  output logic                       valid,
  output icache_pkg::word_t          rd_data
);

  logic [`ICACHE_SETS-1:0] valid_bits;
  logic                    valid_q;
  icache_pkg::tag_t        rd_tag_q;
  icache_pkg::tag_t        tag_q;

  sdp_ram #(
    .payload_t (icache_pkg::tag_t),
    .DEPTH     (`ICACHE_SETS)
  ) i_tag_ram (
    .clk   (clk),
    .we    (tag_we),
    .waddr (wr_set),
    .wdata (wr_tag),
    .raddr (rd_set),
    .rdata (tag_q)
  );

  // Line data, addressed by set then word
  sdp_ram #(
    .payload_t (icache_pkg::word_t),
    .DEPTH     (`ICACHE_SETS * `ICACHE_LINE_WORDS)
  ) i_data_ram (
    .clk   (clk),
    .we    (data_we),
    .waddr ({wr_set, wr_word}),
    .wdata (wr_data),
    .raddr ({rd_set, rd_word}),
    .rdata (rd_data)
  );

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_bits <= '0;
      valid_q    <= 1'b0;
    end
    else
    begin
      if (tag_we)
      begin
        valid_bits[wr_set] <= 1'b1;
      end
      valid_q <= valid_bits[rd_set];
    end
  end

  // Tag to compare arrives with the RAM read
  always_ff @(posedge clk)
  begin
    rd_tag_q <= rd_tag;
  end

  assign valid = valid_q;
  assign hit   = valid_q & (tag_q == rd_tag_q);

endmodule

`default_nettype wire

// File: hw/lru_ages.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module lru_ages (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire icache_pkg::set_t      set,
  input  wire logic                  access_pulse,
  input  wire icache_pkg::way_t      access_way,
  output icache_pkg::way_t           victim,
  input  wire icache_pkg::way_mask_t valid_mask
);

  icache_pkg::age_t ages [`ICACHE_SETS][`ICACHE_WAYS];
  icache_pkg::age_t acc_age;
  icache_pkg::age_t best_age;
  logic             free_found;

  assign acc_age = ages[set][access_way];

  // Accessed way goes to age 0, younger ones grow older
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
      begin
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
          ages[s][w] <= '0;
        end
      end
    end
    else if (access_pulse)
    begin
      for (int w = 0; w < `ICACHE_WAYS; w++)
      begin
        if (icache_pkg::way_t'(w) == access_way)
          ages[set][w] <= '0;
        else if (ages[set][w] <= acc_age)
          ages[set][w] <= ages[set][w] + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Victim choice
  always_comb
  begin
    victim     = '0;
    best_age   = ages[set][0];
    free_found = 1'b0;
    // First empty way wins outright
    for (int w = 0; w < `ICACHE_WAYS; w++)
    begin
      if (!free_found && !valid_mask[w])
      begin
        victim     = icache_pkg::way_t'(w);
        free_found = 1'b1;
      end
    end
    if (!free_found)
    begin
      for (int w = 1; w < `ICACHE_WAYS; w++)
      begin
        if (ages[set][w] > best_age)
        begin
          victim   = icache_pkg::way_t'(w);
          best_age = ages[set][w];
        end
      end
    end
  end

  a_access_way_known: assert property (@(posedge clk) disable iff (rst)
    access_pulse |-> !$isunknown(access_way))
    else $error("lru_ages: unknown access_way during access");

endmodule

`default_nettype wire

// File: hw/refill_unit.sv
`timescale 1ns/1ps
`default_nettype none

module refill_unit (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  refill_start,
  input  wire icache_pkg::way_t      victim,
  input  wire icache_pkg::word_idx_t start_word,
  input  wire logic                  data_ok,
  input  wire icache_pkg::word_t     sdata,
  output icache_pkg::way_mask_t      data_we,
  output icache_pkg::word_idx_t      wr_word,
  output icache_pkg::word_t          wr_data,
  output logic                       refill_done
);

  logic                  active;
  logic                  accept;
  icache_pkg::word_idx_t count;
  icache_pkg::way_t      victim_q;
  icache_pkg::word_idx_t start_q;

  // data_ok counts only while a burst is open
  assign accept = active & data_ok;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      active <= 1'b0;
      count  <= '0;
    end
    else if (refill_start)
    begin
      active <= 1'b1;
      count  <= '0;
    end
    else if (accept)
    begin
      count <= count + 1'b1;
      if (count == '1)
        active <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (refill_start)
    begin
      victim_q <= victim;
      start_q  <= start_word;
    end
  end

  // Burst starts at the missed word and wraps in the line
  assign wr_word     = start_q + count;
  assign wr_data     = sdata;
  assign refill_done = accept & (count == '1);

  always_comb
  begin
    data_we           = '0;
    data_we[victim_q] = accept;
  end

  a_no_restart: assert property (@(posedge clk) disable iff (rst)
    refill_start |-> !active)
    else $error("refill_unit: refill_start during an open refill");

endmodule

`default_nettype wire

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_ctrl (
  input  wire logic                  clk,
  input  wire logic                  rst,
  input  wire logic                  req,
  input  wire icache_pkg::addr_t     insaddr,
  input  wire icache_pkg::way_mask_t hit,
  input  wire icache_pkg::word_t     way_data [`ICACHE_WAYS],
  input  wire icache_pkg::way_t      victim,
  input  wire logic                  refill_done,
  output logic                       ok,
  output icache_pkg::word_t          ins,
  output logic                       sen,
  output icache_pkg::addr_t          addr,
  output icache_pkg::set_t           rd_set,
  output icache_pkg::word_idx_t      rd_word,
  output icache_pkg::tag_t           rd_tag,
  output logic                       access_pulse,
  output icache_pkg::way_t           access_way,
  output logic                       refill_start,
  output icache_pkg::word_idx_t      start_word,
  output icache_pkg::way_mask_t      tag_we
);

  typedef enum logic [1:0] {IDLE, LOOKUP, REFILL, REREAD} state_t;

  state_t            state;
  state_t            state_nx;
  icache_pkg::addr_t addr_q;
  icache_pkg::addr_t cur_addr;
  icache_pkg::way_t  victim_q;
  icache_pkg::way_t  hit_way;
  logic              any_hit;
  logic              tag_wr_q;

  //////////////////////////////
  // Address split
  // Idle reads straight from the CPU so a hit answers next cycle
  assign cur_addr   = (state == IDLE) ? insaddr : addr_q;
  assign rd_word    = cur_addr[`ICACHE_WORD_LSB +: `ICACHE_WORD_W];
  assign rd_set     = cur_addr[`ICACHE_SET_LSB +: `ICACHE_SET_W];
  assign rd_tag     = cur_addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
  assign start_word = addr_q[`ICACHE_WORD_LSB +: `ICACHE_WORD_W];
  assign addr       = {addr_q[`ICACHE_ADDR_W-1:2], 2'b00};

  always_comb
  begin
    hit_way = '0;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
    begin
      if (hit[w])
        hit_way = icache_pkg::way_t'(w);
    end
  end

  assign any_hit = |hit;

  //////////////////////////////
  // Outputs
  assign ok           = (state == LOOKUP) & any_hit;
  assign ins          = way_data[hit_way];
  assign sen          = (state == REFILL);
  assign access_pulse = ok;
  assign access_way   = hit_way;
  assign refill_start = (state == LOOKUP) & ~any_hit;

  always_comb
  begin
    tag_we           = '0;
    tag_we[victim_q] = tag_wr_q;
  end

  //////////////////////////////
  // FSM
  always_comb
  begin
    state_nx = state;
    case (state)
      IDLE:    if (req) state_nx = LOOKUP;
      LOOKUP:  state_nx = any_hit ? IDLE : REFILL;
      REFILL:  if (refill_done) state_nx = REREAD;
      // Tag write cycle and one more to read the line back
      REREAD:  if (!tag_wr_q) state_nx = LOOKUP;
      default: state_nx = IDLE;
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state    <= IDLE;
      tag_wr_q <= 1'b0;
    end
    else
    begin
      state    <= state_nx;
      tag_wr_q <= (state == REFILL) & refill_done;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && req)
      addr_q <= insaddr;
    if (refill_start)
      victim_q <= victim;
  end

  a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(hit))
    else $error("icache_ctrl: more than one way hit");

  a_done_in_refill: assert property (@(posedge clk) disable iff (rst)
    refill_done |-> sen)
    else $error("icache_ctrl: refill_done outside a refill");

endmodule

`default_nettype wire

// File: hw/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_top (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              req,
  input  wire icache_pkg::addr_t insaddr,
  output logic                   ok,
  output icache_pkg::word_t      ins,
  output logic                   sen,
  output icache_pkg::addr_t      addr,
  input  wire logic              data_ok,
  input  wire icache_pkg::word_t sdata
);

  icache_pkg::set_t      rd_set;
  icache_pkg::word_idx_t rd_word;
  icache_pkg::tag_t      rd_tag;
  icache_pkg::way_mask_t hit;
  icache_pkg::way_mask_t valid_mask;
  icache_pkg::word_t     way_data [`ICACHE_WAYS];
  icache_pkg::way_t      victim;
  logic                  access_pulse;
  icache_pkg::way_t      access_way;
  logic                  refill_start;
  icache_pkg::word_idx_t start_word;
  icache_pkg::way_mask_t tag_we;
  icache_pkg::way_mask_t data_we;
  icache_pkg::word_idx_t wr_word;
  icache_pkg::word_t     wr_data;
  logic                  refill_done;

  icache_ctrl i_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .insaddr      (insaddr),
    .hit          (hit),
    .way_data     (way_data),
    .victim       (victim),
    .refill_done  (refill_done),
    .ok           (ok),
    .ins          (ins),
    .sen          (sen),
    .addr         (addr),
    .rd_set       (rd_set),
    .rd_word      (rd_word),
    .rd_tag       (rd_tag),
    .access_pulse (access_pulse),
    .access_way   (access_way),
    .refill_start (refill_start),
    .start_word   (start_word),
    .tag_we       (tag_we)
  );

  // Refill writes go to the set being looked up
  for (genvar g = 0; g < `ICACHE_WAYS; g++)
  begin : g_way
    cache_way i_way (
      .clk     (clk),
      .rst     (rst),
      .rd_set  (rd_set),
      .rd_word (rd_word),
      .rd_tag  (rd_tag),
      .tag_we  (tag_we[g]),
      .wr_set  (rd_set),
      .wr_tag  (rd_tag),
      .data_we (data_we[g]),
      .wr_word (wr_word),
      .wr_data (wr_data),
      .hit     (hit[g]),
      .valid   (valid_mask[g]),
      .rd_data (way_data[g])
    );
  end

  lru_ages i_ages (
    .clk          (clk),
    .rst          (rst),
    .set          (rd_set),
    .access_pulse (access_pulse),
    .access_way   (access_way),
    .victim       (victim),
    .valid_mask   (valid_mask)
  );

  refill_unit i_refill (
    .clk          (clk),
    .rst          (rst),
    .refill_start (refill_start),
    .victim       (victim),
    .start_word   (start_word),
    .data_ok      (data_ok),
    .sdata        (sdata),
    .data_we      (data_we),
    .wr_word      (wr_word),
    .wr_data      (wr_data),
    .refill_done  (refill_done)
  );

endmodule

`default_nettype wire

// File: dv/icache_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module icache_checker (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire logic              req,
  input  wire icache_pkg::addr_t insaddr,
  input  wire logic              ok,
  input  wire icache_pkg::word_t ins,
  input  wire logic              sen,
  input  wire icache_pkg::addr_t addr,
  input  wire logic              data_ok,
  output int                     errors,
  output int                     checks,
  output logic                   refill_seen
);

  logic              m_valid [`ICACHE_SETS][`ICACHE_WAYS];
  icache_pkg::tag_t  m_tag   [`ICACHE_SETS][`ICACHE_WAYS];
  icache_pkg::age_t  m_age   [`ICACHE_SETS][`ICACHE_WAYS];
  logic              pending;
  logic              exp_miss;
  logic              saw_sen;
  icache_pkg::addr_t cur;
  int                cycles;
  int                beats;
  int                after_last;

  assign refill_seen = saw_sen;

  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
    return (a ^ 32'hA5A5_0000) & 32'hFFFF_FFFC;
  endfunction

  // Lowest empty way, else the oldest, lowest index on a tie
  function automatic int pick_victim(input icache_pkg::set_t s);
    int v;
    v = -1;
    for (int w = `ICACHE_WAYS - 1; w >= 0; w--)
      if (!m_valid[s][w])
        v = w;
    if (v < 0)
    begin
      v = 0;
      for (int w = 1; w < `ICACHE_WAYS; w++)
        if (m_age[s][w] > m_age[s][v])
          v = w;
    end
    return v;
  endfunction

  // Decide hit or refill, install on a miss, then age the set
  task automatic predict(input icache_pkg::addr_t a);
    icache_pkg::set_t s;
    icache_pkg::tag_t t;
    icache_pkg::age_t acc;
    int               way;
    s   = a[`ICACHE_SET_LSB +: `ICACHE_SET_W];
    t   = a[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
    way = -1;
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (m_valid[s][w] && m_tag[s][w] == t)
        way = w;
    exp_miss = (way < 0);
    if (exp_miss)
    begin
      way             = pick_victim(s);
      m_valid[s][way] = 1'b1;
      m_tag[s][way]   = t;
    end
    acc = m_age[s][way];
    for (int w = 0; w < `ICACHE_WAYS; w++)
      if (w == way)
        m_age[s][w] = '0;
      else if (m_age[s][w] <= acc)
        m_age[s][w] = m_age[s][w] + 1'b1;
  endtask

  task automatic mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic failure(input string msg);
    $display("Error at %0t ns: %s", $time, msg);
    errors++;
  endtask

  //////////////////////////////
  // Port monitor, one request at a time
  always @(posedge clk)
  begin
    if (rst)
    begin
      for (int s = 0; s < `ICACHE_SETS; s++)
        for (int w = 0; w < `ICACHE_WAYS; w++)
        begin
          m_valid[s][w] = 1'b0;
          m_age[s][w]   = '0;
        end
      pending = 1'b0;
      saw_sen = 1'b0;
      errors  = 0;
      checks  = 0;
    end
    else if (pending)
    begin
      cycles++;
      if (beats == 16)
        after_last++;
      if (sen)
      begin
        if (!saw_sen && !exp_miss)
          failure($sformatf("refill started for 0x%08h, which should hit", cur));
        if (!saw_sen && addr !== {cur[31:2], 2'b00})
          mismatch($sformatf("refill addr 0x%08h, expected 0x%08h", addr, cur));
        if (beats == 16)
          failure("sen still high after the 16th word");
        saw_sen = 1'b1;
        if (data_ok)
        begin
          beats++;
          if (beats == 16)
            after_last = 0;
        end
      end
      if (ok)
      begin
        checks++;
        pending = 1'b0;
        if (ins !== expected_word(cur))
          mismatch($sformatf("ins 0x%08h for 0x%08h, expected 0x%08h",
                             ins, cur, expected_word(cur)));
        if (!exp_miss && cycles != 1)
          mismatch($sformatf("hit answered after %0d cycles, expected 1", cycles));
        if (exp_miss && beats != 16)
          failure($sformatf("0x%08h answered without a full refill", cur));
        else if (exp_miss && after_last != 3)
          mismatch($sformatf("ok %0d cycles after last word, expected 3", after_last));
      end
    end
    else if (ok || sen)
      failure("ok or sen raised with no request open");
    else if (req)
    begin
      cur        = insaddr;
      pending    = 1'b1;
      cycles     = 0;
      beats      = 0;
      after_last = 0;
      saw_sen    = 1'b0;
      predict(insaddr);
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "icache_macros.svh"

module tb_icache;

  // Requests per test, summed for the cycle limit
  localparam int N_REQ = 1 + 4 + 17 + 8 + 9 + 300;
  localparam int LIMIT = 40 * N_REQ;

  logic              clk = 1'b0;
  logic              rst;
  logic              req;
  icache_pkg::addr_t insaddr;
  logic              ok;
  icache_pkg::word_t ins;
  logic              sen;
  icache_pkg::addr_t addr;
  logic              data_ok = 1'b0;
  icache_pkg::word_t sdata = '0;
  int                chk_errors;
  int                chk_checks;
  logic              refill_seen;
  int                tb_errors;
  int                test_base;
  int                served = 0;
  int                cycles = 0;
  int unsigned       gap_roll;
  icache_pkg::word_idx_t beat_word;

  always #50 clk = ~clk;

  icache_top i_dut (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .insaddr (insaddr),
    .ok      (ok),
    .ins     (ins),
    .sen     (sen),
    .addr    (addr),
    .data_ok (data_ok),
    .sdata   (sdata)
  );

  icache_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .req         (req),
    .insaddr     (insaddr),
    .ok          (ok),
    .ins         (ins),
    .sen         (sen),
    .addr        (addr),
    .data_ok     (data_ok),
    .errors      (chk_errors),
    .checks      (chk_checks),
    .refill_seen (refill_seen)
  );

  function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a);
    return {a[31:2], 2'b00} ^ 32'hA5A5_0000;
  endfunction

  function automatic icache_pkg::addr_t make_addr(input int tag, input int set, input int word);
    return {tag[`ICACHE_TAG_W-1:0], set[`ICACHE_SET_W-1:0], word[`ICACHE_WORD_W-1:0], 2'b00};
  endfunction

  //////////////////////////////
  // Memory, wrapping burst with random gaps
  always @(negedge clk)
  begin
    if (!sen)
    begin
      served  = 0;
      data_ok = 1'b0;
    end
    else
    begin
      gap_roll = $urandom;
      if (served < 16 && gap_roll[1:0] != 2'b00)
      begin
        beat_word = addr[`ICACHE_WORD_LSB +: `ICACHE_WORD_W] + served[3:0];
        sdata     = mem_word({addr[`ICACHE_ADDR_W-1:`ICACHE_SET_LSB], beat_word, 2'b00});
        data_ok   = 1'b1;
        served++;
      end
      else
        data_ok = 1'b0;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > LIMIT)
    begin
      $display("Timeout: run did not finish within %0d cycles", LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  // Expect 0 or 1 checks the refill decision, 2 leaves it to the model
  task automatic fetch(input icache_pkg::addr_t a, input int expect_refill);
    req     = 1'b1;
    insaddr = a;
    @(negedge clk);
    while (ok !== 1'b1)
      @(negedge clk);
    if (expect_refill != 2 && refill_seen !== expect_refill[0])
    begin
      $display("Mismatch at %0t ns: refill for 0x%08h was %0b, expected %0b",
               $time, a, refill_seen, expect_refill[0]);
      tb_errors++;
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    req = 1'b0;
    @(negedge clk);
    errs = chk_errors + tb_errors - test_base;
    $display("Test %-14s done, %0d errors", name, errs);
    test_base = chk_errors + tb_errors;
  endtask

  initial
  begin
    int unsigned roll;
    void'($urandom(1));
    rst       = 1'b1;
    req       = 1'b0;
    insaddr   = '0;
    tb_errors = 0;
    test_base = 0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    fetch(make_addr('h100, 3, 5), 1);
    finish_test("cold_miss");

    fetch(make_addr('h100, 3, 5), 0);
    fetch(make_addr('h100, 3, 0), 0);
    fetch(make_addr('h100, 3, 15), 0);
    fetch(make_addr('h100, 3, 7), 0);
    finish_test("hit_latency");

    fetch(make_addr('h200, 7, 9), 1);
    for (int w = 0; w < 16; w++)
      fetch(make_addr('h200, 7, w), 0);
    finish_test("wrap_order");

    for (int t = 0; t < 4; t++)
      fetch(make_addr('h300 + t, 12, t), 1);
    for (int t = 0; t < 4; t++)
      fetch(make_addr('h300 + t, 12, 15 - t), 0);
    finish_test("fill_invalid");

    // Leaves tag 302 oldest, so 304 replaces it
    fetch(make_addr('h302, 12, 1), 0);
    fetch(make_addr('h300, 12, 2), 0);
    fetch(make_addr('h303, 12, 3), 0);
    fetch(make_addr('h301, 12, 4), 0);
    fetch(make_addr('h304, 12, 5), 1);
    fetch(make_addr('h300, 12, 6), 0);
    fetch(make_addr('h303, 12, 7), 0);
    fetch(make_addr('h301, 12, 8), 0);
    fetch(make_addr('h302, 12, 9), 1);
    finish_test("lru_eviction");

    for (int i = 0; i < 300; i++)
    begin
      roll = $urandom;
      fetch(make_addr(16 + int'((roll >> 8) % 6), int'(roll[0]), int'(roll[7:4])), 2);
      if (roll[13:12] == 2'b00)
      begin
        req = 1'b0;
        @(negedge clk);
      end
    end
    finish_test("random_traffic");

    $display("Summary: %0d requests checked, %0d errors", chk_checks, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hw
hw/icache_pkg.sv
hw/sdp_ram.sv
hw/cache_way.sv
hw/lru_ages.sv
hw/refill_unit.sv
hw/icache_ctrl.sv
hw/icache_top.sv
dv/icache_checker.sv
dv/tb_icache.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_icache -f compile.f -o sim_icache
./obj_dir/sim_icache 2>&1 | tee sim.log

if grep -qF "** FAIL **" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -qF "** PASS **" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
